//--- all.f
common/qdsp_pkg.sv
common/qcmd_if.sv
hw/data_xdomain.sv
qcmd/qcmd_gen.sv
hw/dac_chan.sv
hw/minmax2.sv
hw/digimark.sv
hw/qubicdsp.sv
verif/tb_clkgen.sv
verif/qubicdsp_assertions.sv
verif/qubicdsp_tb.sv

//--- common/qcmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface qcmd_if ();
	import qdsp_pkg::*;

	qcmd_u command; // valid with cstrobe
	logic [CMDA_W-1:0] cmda; // consumer select
	logic cstrobe; // one cycle per played entry
	logic trig; // period tick

	// sequencer side
	modport src (
		output command,
		output cmda,
		output cstrobe,
		output trig
	);

	// consumers decode their own cmda
	modport sink (
		input command,
		input cmda,
		input cstrobe,
		input trig
	);

endinterface

`default_nettype wire

//--- common/qdsp_pkg.sv
`default_nettype none

package qdsp_pkg;

	localparam int DW = 16; // sample width
	localparam int TSLICE = 4; // samples per clk
	localparam int NDAC = 4;
	localparam int NMARK = 2;
	localparam int LB_AW = 20; // local bus word address
	localparam int LB_DW = 32;
	localparam int CFG_AW = LB_AW - 2; // offset below the region field
	localparam int CMDA_W = 8;
	localparam int HOLD_W = 16; // marker hold count
	localparam int CMD_ENTRIES = 16; // four words each
	localparam int CMD_ENT_AW = $clog2(CMD_ENTRIES);

	localparam logic [1:0] REGION_CFG = 2'd0; // addr[19:18]
	localparam logic [1:0] REGION_CMD = 2'd2; // 0x80000

	localparam int CFG_PERIOD = 0; // trigger period or 0 for off
	localparam int CFG_DC_BASE = 1; // dc offsets at words 1..4

	localparam int CMDA_DAC_BASE = 0; // 0..3
	localparam int CMDA_MINMAX = 8;
	localparam int CMDA_MARK_BASE = 12; // 12, 13
	localparam int CMDA_END = 255; // stops playback

	localparam logic [DW-1:0] SAMP_MAX = {1'b0, {(DW - 1){1'b1}}}; // 0x7fff
	localparam logic [DW-1:0] SAMP_MIN = {1'b1, {(DW - 1){1'b0}}}; // 0x8000

	// marker view with level in bit 0 and hold count above it
	typedef struct packed {
		logic [TSLICE*DW-HOLD_W-2:0] pad;
		logic [HOLD_W-1:0] hold;
		logic level;
	} mark_view_t;

	typedef union packed {
		logic [TSLICE-1:0][DW-1:0] dac; // slice 0 in low bits, signed samples
		mark_view_t mark;
	} qcmd_u;

endpackage

`default_nettype wire

//--- hw/dac_chan.sv
`timescale 1ns/1ps
`default_nettype none

module dac_chan #(
	parameter int CHAN = 0
) (
	input logic clk,
	input logic rst_n,
	input logic [qdsp_pkg::LB_AW-1:0] d_addr,
	input logic [qdsp_pkg::LB_DW-1:0] d_wdata,
	input logic d_write,
	qcmd_if.sink cmd,
	output logic [qdsp_pkg::TSLICE*qdsp_pkg::DW-1:0] dac
);
	import qdsp_pkg::*;

	localparam logic [CMDA_W-1:0] MY_CMDA = CMDA_W'(CMDA_DAC_BASE + CHAN);
	localparam logic [CFG_AW-1:0] DC_ADDR = CFG_AW'(CFG_DC_BASE + CHAN);

	logic [TSLICE-1:0][DW-1:0] amp; // latched amplitudes
	logic [TSLICE-1:0][DW-1:0] amp_nxt;
	logic [TSLICE-1:0][DW-1:0] sum; // saturated slices
	logic [DW-1:0] dc; // offset shared by all slices
	logic [DW-1:0] dc_nxt;
	logic amp_hit;
	logic dc_hit;

	function automatic logic [DW-1:0] sat_add(input logic [DW-1:0] a, input logic [DW-1:0] b);
		logic signed [DW:0] s;
		s = $signed({a[DW-1], a}) + $signed({b[DW-1], b}); // one guard bit
		if (s[DW] == s[DW-1]) begin
			return s[DW-1:0];
		end
		return s[DW] ? SAMP_MIN : SAMP_MAX; // clip on overflow
	endfunction

	assign amp_hit = cmd.cstrobe && cmd.cmda == MY_CMDA;
	assign dc_hit = d_write && d_addr[LB_AW-1 -: 2] == REGION_CFG
		&& d_addr[CFG_AW-1:0] == DC_ADDR;

	// new values go straight into the sum
	assign amp_nxt = amp_hit ? cmd.command.dac : amp;
	assign dc_nxt = dc_hit ? d_wdata[DW-1:0] : dc;

	always_comb begin
		for (int i = 0; i < TSLICE; i++) begin
			sum[i] = sat_add(amp_nxt[i], dc_nxt);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			amp <= '0;
			dc <= '0;
			dac <= '0;
		end else begin
			amp <= amp_nxt;
			dc <= dc_nxt;
			dac <= sum;
		end
	end

endmodule

`default_nettype wire

//--- hw/data_xdomain.sv
`timescale 1ns/1ps
`default_nettype none

module data_xdomain (
	input logic lb_clk,
	input logic clk,
	input logic rst_n,
	input logic [qdsp_pkg::LB_AW-1:0] lb_addr,
	input logic [qdsp_pkg::LB_DW-1:0] lb_wdata,
	input logic lb_write,
	output logic [qdsp_pkg::LB_AW-1:0] d_addr,
	output logic [qdsp_pkg::LB_DW-1:0] d_wdata,
	output logic d_write
);
	import qdsp_pkg::*;

	logic [LB_AW-1:0] hold_addr; // lb_clk side copy
	logic [LB_DW-1:0] hold_wdata;
	logic tog_lb; // flips once per write
	logic [2:0] tog_sync; // two sync stages plus edge history
	logic tog_edge;

	always_ff @(posedge lb_clk) begin
		if (lb_write) begin
			hold_addr <= lb_addr; // stays put until the next write
			hold_wdata <= lb_wdata;
		end
	end

	always_ff @(posedge lb_clk or negedge rst_n) begin
		if (!rst_n) begin
			tog_lb <= 1'b0;
		end else if (lb_write) begin
			tog_lb <= ~tog_lb;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tog_sync <= '0;
		end else begin
			tog_sync <= {tog_sync[1:0], tog_lb}; // [0] may go metastable
		end
	end

	assign tog_edge = tog_sync[2] ^ tog_sync[1]; // either polarity is a write

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_write <= 1'b0;
		end else begin
			d_write <= tog_edge;
		end
	end

	// hold regs settled long before the toggle arrives
	always_ff @(posedge clk) begin
		if (tog_edge) begin
			d_addr <= hold_addr;
			d_wdata <= hold_wdata;
		end
	end

endmodule

`default_nettype wire

//--- hw/digimark.sv
`timescale 1ns/1ps
`default_nettype none

module digimark #(
	parameter int IDX = 0
) (
	input logic clk,
	input logic rst_n,
	qcmd_if.sink cmd,
	output logic mark
);
	import qdsp_pkg::*;

	localparam logic [CMDA_W-1:0] MY_CMDA = CMDA_W'(CMDA_MARK_BASE + IDX);

	logic [HOLD_W-1:0] hold_cnt; // cycles left at the commanded level
	logic hit;

	assign hit = cmd.cstrobe && cmd.cmda == MY_CMDA;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mark <= 1'b0;
			hold_cnt <= '0;
		end else if (hit) begin
			mark <= cmd.command.mark.level;
			hold_cnt <= cmd.command.mark.hold; // 0 holds forever
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
			if (hold_cnt == HOLD_W'(1)) begin
				mark <= 1'b0; // last cycle of the hold
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/minmax2.sv
`timescale 1ns/1ps
`default_nettype none

module minmax2 (
	input logic clk,
	input logic rst_n,
	input logic [qdsp_pkg::TSLICE*qdsp_pkg::DW-1:0] xin,
	qcmd_if.sink cmd,
	output logic [qdsp_pkg::DW-1:0] xmin,
	output logic [qdsp_pkg::DW-1:0] xmax
);
	import qdsp_pkg::*;

	logic [TSLICE-1:0][DW-1:0] xin_r; // input register
	logic signed [DW-1:0] smin; // extremes of this word
	logic signed [DW-1:0] smax;
	logic clr;

	assign clr = cmd.cstrobe && cmd.cmda == CMDA_W'(CMDA_MINMAX);

	always_ff @(posedge clk) begin
		xin_r <= xin;
	end

	// reduce the slices of one word
	always_comb begin
		smin = $signed(xin_r[0]);
		smax = $signed(xin_r[0]);
		for (int i = 1; i < TSLICE; i++) begin
			if ($signed(xin_r[i]) < smin) begin
				smin = $signed(xin_r[i]);
			end
			if ($signed(xin_r[i]) > smax) begin
				smax = $signed(xin_r[i]);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xmin <= SAMP_MAX; // empty history
			xmax <= SAMP_MIN;
		end else if (clr) begin
			xmin <= SAMP_MAX; // drops the word in flight too
			xmax <= SAMP_MIN;
		end else begin
			if (smin < $signed(xmin)) begin
				xmin <= smin;
			end
			if (smax > $signed(xmax)) begin
				xmax <= smax;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/qubicdsp.sv
`timescale 1ns/1ps
`default_nettype none

module qubicdsp (
	input wire clk,
	input wire lb_clk,
	input wire rst_n,
	input wire [qdsp_pkg::LB_AW-1:0] lb_addr,
	input wire [qdsp_pkg::LB_DW-1:0] lb_wdata,
	input wire lb_write,
	input wire [qdsp_pkg::TSLICE*qdsp_pkg::DW-1:0] adc0,
	input wire [qdsp_pkg::TSLICE*qdsp_pkg::DW-1:0] adc1,
	output wire [qdsp_pkg::TSLICE*qdsp_pkg::DW-1:0] dac0,
	output wire [qdsp_pkg::TSLICE*qdsp_pkg::DW-1:0] dac1,
	output wire [qdsp_pkg::TSLICE*qdsp_pkg::DW-1:0] dac2,
	output wire [qdsp_pkg::TSLICE*qdsp_pkg::DW-1:0] dac3,
	output wire [qdsp_pkg::DW-1:0] adc0_min,
	output wire [qdsp_pkg::DW-1:0] adc0_max,
	output wire [qdsp_pkg::DW-1:0] adc1_min,
	output wire [qdsp_pkg::DW-1:0] adc1_max,
	output wire [qdsp_pkg::NMARK-1:0] mark,
	output wire trig
);
	import qdsp_pkg::*;

	wire [LB_AW-1:0] d_addr; // dsp domain copy of the write
	wire [LB_DW-1:0] d_wdata;
	wire d_write;
	wire [TSLICE*DW-1:0] dac_w [NDAC];

	qcmd_if cmd_bus (); // played commands

	data_xdomain data_xdomain_inst (
		.lb_clk(lb_clk),
		.clk(clk),
		.rst_n(rst_n),
		.lb_addr(lb_addr),
		.lb_wdata(lb_wdata),
		.lb_write(lb_write),
		.d_addr(d_addr),
		.d_wdata(d_wdata),
		.d_write(d_write)
	);

	qcmd_gen qcmd_gen_inst (
		.clk(clk),
		.rst_n(rst_n),
		.d_addr(d_addr),
		.d_wdata(d_wdata),
		.d_write(d_write),
		.cmd(cmd_bus.src)
	);

	for (genvar ch = 0; ch < NDAC; ch++) begin : gen_dac
		dac_chan #(.CHAN(ch)) dac_chan_inst (
			.clk(clk),
			.rst_n(rst_n),
			.d_addr(d_addr),
			.d_wdata(d_wdata),
			.d_write(d_write),
			.cmd(cmd_bus.sink),
			.dac(dac_w[ch])
		);
	end

	assign dac0 = dac_w[0];
	assign dac1 = dac_w[1];
	assign dac2 = dac_w[2];
	assign dac3 = dac_w[3];

	// both trackers clear on the same command
	minmax2 adc0_minmax (
		.clk(clk),
		.rst_n(rst_n),
		.xin(adc0),
		.cmd(cmd_bus.sink),
		.xmin(adc0_min),
		.xmax(adc0_max)
	);

	minmax2 adc1_minmax (
		.clk(clk),
		.rst_n(rst_n),
		.xin(adc1),
		.cmd(cmd_bus.sink),
		.xmin(adc1_min),
		.xmax(adc1_max)
	);

	for (genvar m = 0; m < NMARK; m++) begin : gen_mark
		digimark #(.IDX(m)) digimark_inst (
			.clk(clk),
			.rst_n(rst_n),
			.cmd(cmd_bus.sink),
			.mark(mark[m])
		);
	end

	assign trig = cmd_bus.trig;

endmodule

`default_nettype wire

//--- qcmd/qcmd_gen.sv
`timescale 1ns/1ps
`default_nettype none

module qcmd_gen (
	input logic clk,
	input logic rst_n,
	input logic [qdsp_pkg::LB_AW-1:0] d_addr,
	input logic [qdsp_pkg::LB_DW-1:0] d_wdata,
	input logic d_write,
	qcmd_if.src cmd
);
	import qdsp_pkg::*;

	logic [LB_DW-1:0] mem_lo [CMD_ENTRIES]; // word 0
	logic [LB_DW-1:0] mem_hi [CMD_ENTRIES]; // word 1
	logic [23:0] mem_ctl [CMD_ENTRIES]; // word 2 holds delay and cmda
	logic [LB_DW-1:0] period;
	logic [LB_DW-1:0] trig_cnt;
	logic busy; // playback running
	logic [CMD_ENT_AW-1:0] ptr; // entry being played
	logic [15:0] wait_cnt; // cycles left before the next entry
	logic cmd_wr;
	logic period_wr;
	logic fire;
	logic strobe;
	logic [CMDA_W-1:0] ent_cmda;
	logic [15:0] ent_delay;

	assign cmd_wr = d_write && d_addr[LB_AW-1 -: 2] == REGION_CMD;
	assign period_wr = d_write && d_addr[LB_AW-1 -: 2] == REGION_CFG
		&& d_addr[CFG_AW-1:0] == CFG_AW'(CFG_PERIOD);

	// word index in addr[1:0] with the entry above it
	always_ff @(posedge clk) begin
		if (cmd_wr) begin
			case (d_addr[1:0])
				2'd0: mem_lo[d_addr[2 +: CMD_ENT_AW]] <= d_wdata;
				2'd1: mem_hi[d_addr[2 +: CMD_ENT_AW]] <= d_wdata;
				2'd2: mem_ctl[d_addr[2 +: CMD_ENT_AW]] <= d_wdata[23:0];
				default: ; // word 3 unused
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			period <= '0;
			trig_cnt <= '0;
			cmd.trig <= 1'b0;
		end else if (period_wr) begin
			period <= d_wdata;
			trig_cnt <= '0; // restart the count
			cmd.trig <= 1'b0;
		end else if (period == '0) begin
			cmd.trig <= 1'b0; // off
		end else if (trig_cnt == period - 1'b1) begin
			trig_cnt <= '0;
			cmd.trig <= 1'b1;
		end else begin
			trig_cnt <= trig_cnt + 1'b1;
			cmd.trig <= 1'b0;
		end
	end

	assign ent_cmda = mem_ctl[ptr][7:0];
	assign ent_delay = mem_ctl[ptr][23:8];
	assign fire = busy && wait_cnt == '0; // current entry is due
	assign strobe = fire && ent_cmda != CMDA_W'(CMDA_END);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			ptr <= '0;
			wait_cnt <= '0;
			cmd.cstrobe <= 1'b0;
		end else begin
			cmd.cstrobe <= strobe;
			if (!busy) begin
				if (cmd.trig) begin
					busy <= 1'b1; // entry 0 fires next cycle
					ptr <= '0;
					wait_cnt <= '0;
				end
			end else if (!fire) begin
				wait_cnt <= wait_cnt - 1'b1;
			end else if (!strobe) begin
				busy <= 1'b0; // end marker
			end else begin
				wait_cnt <= (ent_delay == '0) ? '0 : ent_delay - 1'b1; // min gap 1
				ptr <= ptr + 1'b1;
				if (ptr == CMD_ENT_AW'(CMD_ENTRIES - 1)) begin
					busy <= 1'b0; // ran off the last entry
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (strobe) begin
			cmd.command <= {mem_hi[ptr], mem_lo[ptr]};
			cmd.cmda <= ent_cmda;
		end
	end

endmodule

`default_nettype wire

//--- verif/qubicdsp_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module qubicdsp_assertions (
	input logic clk,
	input logic rst_n,
	input logic trig,
	input logic cstrobe,
	input logic d_write
);

	int unsigned fail_count;

	initial fail_count = 0;

	// trigger is a single cycle pulse
	trig_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		trig |=> !trig)
		else begin
			fail_count++;
			$error("trig held longer than one cycle");
		end

	// no strobe in the cycle right after trig
	cstrobe_after_trig: assert property (@(posedge clk) disable iff (!rst_n)
		trig |=> !cstrobe)
		else begin
			fail_count++;
			$error("cstrobe one cycle after trig");
		end

	d_write_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		d_write |=> !d_write)
		else begin
			fail_count++;
			$error("d_write held longer than one cycle");
		end

endmodule

bind qubicdsp qubicdsp_assertions protocol_chk (
	.clk(clk),
	.rst_n(rst_n),
	.trig(trig),
	.cstrobe(cmd_bus.cstrobe),
	.d_write(d_write)
);

`default_nettype wire

//--- verif/qubicdsp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module qubicdsp_tb;
	import qdsp_pkg::*;

	localparam int DRIVE_DLY = 2; // after the rising edge
	localparam int SAMPLE_DLY = 1; // outputs settled by then
	localparam int PERIOD_RUN = 200; // longer than any playback
	localparam int H0 = 6; // marker hold counts
	localparam int H1 = 4;

	logic clk;
	logic lb_clk;
	logic rst_n;
	logic [LB_AW-1:0] lb_addr;
	logic [LB_DW-1:0] lb_wdata;
	logic lb_write;
	logic [TSLICE*DW-1:0] adc0;
	logic [TSLICE*DW-1:0] adc1;
	wire [TSLICE*DW-1:0] dac_out [NDAC];
	wire [DW-1:0] adc0_min;
	wire [DW-1:0] adc0_max;
	wire [DW-1:0] adc1_min;
	wire [DW-1:0] adc1_max;
	wire [NMARK-1:0] mark;
	wire trig;

	integer seed;
	logic [DW-1:0] amp [NDAC][TSLICE]; // model of the dac commands
	logic [DW-1:0] dc [NDAC];
	int mn0, mx0, mn1, mx1; // model extremes

	tb_clkgen clkgen_inst (
		.clk(clk),
		.lb_clk(lb_clk),
		.rst_n(rst_n)
	);

	qubicdsp qubicdsp_inst (
		.clk(clk),
		.lb_clk(lb_clk),
		.rst_n(rst_n),
		.lb_addr(lb_addr),
		.lb_wdata(lb_wdata),
		.lb_write(lb_write),
		.adc0(adc0),
		.adc1(adc1),
		.dac0(dac_out[0]),
		.dac1(dac_out[1]),
		.dac2(dac_out[2]),
		.dac3(dac_out[3]),
		.adc0_min(adc0_min),
		.adc0_max(adc0_max),
		.adc1_min(adc1_min),
		.adc1_max(adc1_max),
		.mark(mark),
		.trig(trig)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else abort_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
			$time, what, got, exp));
	endtask

	task automatic tick();
		@(posedge clk);
		#SAMPLE_DLY;
	endtask

	task automatic drive_edge();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// one write then idle to keep six lb_clk cycles between writes
	task automatic bus_write(input logic [LB_AW-1:0] addr, input logic [LB_DW-1:0] data);
		@(posedge lb_clk);
		#DRIVE_DLY;
		lb_addr = addr;
		lb_wdata = data;
		lb_write = 1'b1;
		@(posedge lb_clk);
		#DRIVE_DLY;
		lb_write = 1'b0;
		repeat (5) @(posedge lb_clk);
	endtask

	task automatic cfg_write(input int word, input logic [LB_DW-1:0] data);
		bus_write({REGION_CFG, CFG_AW'(word)}, data);
	endtask

	task automatic put_entry(input int idx, input int cmda, input int delay, input qcmd_u word);
		logic [LB_AW-1:0] base;
		base = {REGION_CMD, CFG_AW'(idx * 4)}; // four words per entry
		bus_write(base, word[31:0]);
		bus_write(base + 1, word[63:32]);
		bus_write(base + 2, {8'h00, 16'(delay), 8'(cmda)});
	endtask

	task automatic wait_trig(input int limit, output int cycles);
		cycles = 0;
		do begin
			tick();
			cycles++;
		end while (trig !== 1'b1 && cycles < limit);
		if (trig !== 1'b1) begin
			abort_run("timeout: no trig pulse arrived");
		end
	endtask

	// returns in the cycle where trig is high
	task automatic start_playback();
		int n;
		cfg_write(CFG_PERIOD, PERIOD_RUN);
		wait_trig(PERIOD_RUN + 50, n);
	endtask

	function automatic logic [DW-1:0] sat_sum(input logic [DW-1:0] a, input logic [DW-1:0] b);
		int s;
		s = int'($signed(a)) + int'($signed(b));
		if (s > 32767) return 16'h7fff;
		if (s < -32768) return 16'h8000;
		return 16'(s);
	endfunction

	task automatic fold(input logic [63:0] word, inout int lo, inout int hi);
		int v;
		for (int s = 0; s < TSLICE; s++) begin
			v = int'($signed(word[DW*s +: DW]));
			if (v < lo) lo = v;
			if (v > hi) hi = v;
		end
	endtask

	always @(posedge clk) begin
		if (qubicdsp_inst.protocol_chk.fail_count != 0) begin
			abort_run("protocol assertion fired in the DUT");
		end
	end

	initial begin
		int n;
		int waited;
		qcmd_u w;
		logic [1:0] exp_mark;

		seed = 32'h9c62_7b1d;
		lb_addr = '0;
		lb_wdata = '0;
		lb_write = 1'b0;
		adc0 = '0;
		adc1 = '0;

		waited = 0;
		while (rst_n !== 1'b1 && waited < 500) begin
			#1;
			waited++;
		end
		if (rst_n !== 1'b1) abort_run("timeout: reset was never released");
		expect_eq("trig after reset", trig, 0);
		expect_eq("mark after reset", mark, 0);
		for (int ch = 0; ch < NDAC; ch++) begin
			expect_eq($sformatf("dac%0d after reset", ch), dac_out[ch], 0);
		end
		expect_eq("adc0_min after reset", adc0_min, 16'h7fff);
		expect_eq("adc0_max after reset", adc0_max, 16'h8000);
		expect_eq("adc1_min after reset", adc1_min, 16'h7fff);
		expect_eq("adc1_max after reset", adc1_max, 16'h8000);

		// trigger period with a playback that ends at once
		put_entry(0, CMDA_END, 0, '0);
		cfg_write(CFG_PERIOD, 7);
		wait_trig(40, n);
		repeat (3) begin
			wait_trig(40, n);
			expect_eq("trig spacing", n, 7);
		end
		cfg_write(CFG_PERIOD, 0);
		repeat (30) begin
			tick();
			expect_eq("trig with period 0", trig, 0);
		end

		// dac channels with random values plus both saturation directions
		for (int ch = 0; ch < NDAC; ch++) begin
			dc[ch] = 16'($random(seed));
			for (int s = 0; s < TSLICE; s++) amp[ch][s] = 16'($random(seed));
		end
		dc[2] = 16'ha000;
		amp[2][0] = 16'h8001; // clips low
		dc[3] = 16'h6000;
		amp[3][0] = 16'h7fff; // clips high
		for (int ch = 0; ch < NDAC; ch++) begin
			cfg_write(CFG_DC_BASE + ch, {16'h0000, dc[ch]});
			w = '0;
			for (int s = 0; s < TSLICE; s++) w.dac[s] = amp[ch][s];
			put_entry(ch, CMDA_DAC_BASE + ch, ch, w); // delay 0 acts as 1
		end
		put_entry(NDAC, CMDA_END, 0, '0);
		start_playback();
		cfg_write(CFG_PERIOD, 0);
		repeat (10) tick();
		for (int ch = 0; ch < NDAC; ch++) begin
			for (int s = 0; s < TSLICE; s++) begin
				expect_eq($sformatf("dac%0d slice %0d", ch, s), dac_out[ch][DW*s +: DW],
					sat_sum(amp[ch][s], dc[ch]));
			end
		end

		// min/max where extremes before the clear must vanish
		put_entry(0, CMDA_MINMAX, 1, '0);
		put_entry(1, CMDA_END, 0, '0);
		drive_edge();
		adc0 = {16'h7fff, 16'h8000, 16'h0000, 16'h0000};
		adc1 = {16'h0000, 16'h0000, 16'h8000, 16'h7fff};
		repeat (3) tick();
		drive_edge();
		adc0 = '0;
		adc1 = '0;
		mn0 = 0; // zero words still flow after the clear
		mx0 = 0;
		mn1 = 0;
		mx1 = 0;
		start_playback();
		cfg_write(CFG_PERIOD, 0);
		repeat (60) begin
			drive_edge();
			adc0 = {$random(seed), $random(seed)};
			adc1 = {$random(seed), $random(seed)};
			fold(adc0, mn0, mx0);
			fold(adc1, mn1, mx1);
		end
		repeat (4) tick(); // adc held steady
		expect_eq("adc0_min", adc0_min, mn0[DW-1:0]);
		expect_eq("adc0_max", adc0_max, mx0[DW-1:0]);
		expect_eq("adc1_min", adc1_min, mn1[DW-1:0]);
		expect_eq("adc1_max", adc1_max, mx1[DW-1:0]);

		// markers with entry 3 past the end marker
		w = '0;
		w.mark.level = 1'b1;
		w.mark.hold = 16'(H0);
		put_entry(0, CMDA_MARK_BASE, 2, w);
		w.mark.hold = 16'(H1);
		put_entry(1, CMDA_MARK_BASE + 1, 3, w);
		put_entry(2, CMDA_END, 0, '0);
		w.mark.hold = '0; // would hold mark 0 high for good
		put_entry(3, CMDA_MARK_BASE, 1, w);
		start_playback();
		for (int k = 1; k <= 40; k++) begin
			tick();
			exp_mark[0] = (k >= 3) && (k < 3 + H0); // strobe at trig + 2
			exp_mark[1] = (k >= 5) && (k < 5 + H1); // two cycles later
			expect_eq($sformatf("mark %0d cycles after trig", k), mark, exp_mark);
		end
		cfg_write(CFG_PERIOD, 0);

		if (qubicdsp_inst.protocol_chk.fail_count != 0) begin
			abort_run("protocol assertion fired in the DUT");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int CLK_HALF = 10, // 20 ns dsp clock
	parameter int LB_HALF = 15, // 30 ns local bus clock
	parameter int RST_CYCLES = 4,
	parameter int DRIVE_DLY = 2
) (
	output logic clk,
	output logic lb_clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	initial begin
		lb_clk = 1'b0;
		forever #LB_HALF lb_clk = ~lb_clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1; // released just after an edge
	end

endmodule

`default_nettype wire
